// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int ADDR_W = 11;    // 2 KB part, block bits are addr[10:8]
    localparam int DATA_W = 8;

    localparam int CMD_DEPTH = 4;
    localparam int RSP_DEPTH = 4;

    // two-wire timing, in CLK cycles
    localparam int SCL_HALF  = 4;
    localparam int SCL_CNT_W = $clog2(2 * SCL_HALF);

    // positions inside one bit slot
    localparam logic [SCL_CNT_W-1:0] SCL_RISE     = SCL_CNT_W'(SCL_HALF);
    localparam logic [SCL_CNT_W-1:0] SCL_LOW_MID  = SCL_CNT_W'(SCL_HALF / 2);
    localparam logic [SCL_CNT_W-1:0] SCL_HIGH_MID = SCL_CNT_W'(SCL_HALF + SCL_HALF / 2);
    localparam logic [SCL_CNT_W-1:0] SCL_LAST     = SCL_CNT_W'(2 * SCL_HALF - 1);

    localparam logic [3:0] DEV_CODE = 4'b1010;    // fixed control byte nibble

    // apb byte offsets
    localparam logic [3:0] REG_WDATA  = 4'h0;
    localparam logic [3:0] REG_CMD    = 4'h4;
    localparam logic [3:0] REG_RDATA  = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    localparam int CMD_RD_BIT = 16;    // read flag inside a REG_CMD write

    // one queued transfer
    typedef struct packed {
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } eeprom_cmd_t;

endpackage

// ==== design/eeprom_fifo.sv ====
`timescale 1ns/100ps

module eeprom_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign do_push  = push && !full;    // push while full is dropped
    assign do_pop   = pop && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or both at once
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

// ==== design/eeprom_apb_regs.sv ====
`timescale 1ns/100ps

module eeprom_apb_regs (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [3:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          cmd_push,
    output eeprom_pkg::eeprom_cmd_t       cmd_data,
    input  logic                          cmd_full,
    output logic                          rsp_pop,
    input  logic [eeprom_pkg::DATA_W-1:0] rsp_data,
    input  logic                          rsp_empty,
    input  logic                          busy,
    input  logic                          nack
);

    logic                          access;
    logic                          wr_wdata;
    logic                          wr_cmd;
    logic                          rd_rdata;
    logic                          rd_status;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;
    logic                          nack_q;

    // apb access phase decode
    assign access    = psel && penable;
    assign wr_wdata  = access && pwrite && (paddr == eeprom_pkg::REG_WDATA);
    assign wr_cmd    = access && pwrite && (paddr == eeprom_pkg::REG_CMD);
    assign rd_rdata  = access && !pwrite && (paddr == eeprom_pkg::REG_RDATA);
    assign rd_status = access && !pwrite && (paddr == eeprom_pkg::REG_STATUS);

    // hold the host until a command slot frees
    assign pready   = !(wr_cmd && cmd_full);
    assign cmd_push = wr_cmd && !cmd_full;

    assign cmd_data.rd    = pwdata[eeprom_pkg::CMD_RD_BIT];
    assign cmd_data.addr  = pwdata[eeprom_pkg::ADDR_W-1:0];
    assign cmd_data.wdata = wdata_q;

    // empty read data fifo is an error, nothing popped
    assign rsp_pop = rd_rdata && !rsp_empty;
    assign pslverr = rd_rdata && rsp_empty;

    always_comb
    begin
        case (paddr)
            eeprom_pkg::REG_WDATA:
                prdata = 32'(wdata_q);
            eeprom_pkg::REG_RDATA:
                prdata = rsp_empty ? 32'd0 : 32'(rsp_data);
            eeprom_pkg::REG_STATUS:
                prdata = 32'({nack_q, !rsp_empty, cmd_full, busy});
            default:
                prdata = 32'd0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (wr_wdata)
            wdata_q <= pwdata[eeprom_pkg::DATA_W-1:0];
    end

    // sticky nack, a new nack wins over the clearing read
    always_ff @(posedge CLK)
    begin
        if (RESET)
            nack_q <= 1'b0;
        else if (nack)
            nack_q <= 1'b1;
        else if (rd_status)
            nack_q <= 1'b0;
    end

endmodule

// ==== design/eeprom_serial_ctrl.sv ====
`timescale 1ns/100ps

module eeprom_serial_ctrl (
    input  logic                            CLK,
    input  logic                            RESET,
    output logic                            cmd_pop,
    input  eeprom_pkg::eeprom_cmd_t         cmd_data,
    input  logic                            cmd_empty,
    output logic                            rsp_push,
    output logic [eeprom_pkg::DATA_W-1:0]   rsp_data,
    output logic                            busy,
    output logic                            nack,
    output logic                            scl,
    output logic                            sda_drive_low,
    input  logic                            sda_in
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RSTART,
        ST_CTRL_R,
        ST_DATA_IN,
        ST_STOP
    } state_t;

    state_t                          state;
    logic [eeprom_pkg::SCL_CNT_W-1:0] cnt;        // position inside one bit slot
    logic [3:0]                      bit_idx;    // 0..7 data bits, 8 ack slot
    logic [eeprom_pkg::DATA_W-1:0]   shreg;
    logic [eeprom_pkg::DATA_W-1:0]   rxreg;
    eeprom_pkg::eeprom_cmd_t         cmd_q;
    logic                            ack_q;
    logic                            rd_ok;
    logic                            slot_end;
    logic                            ack_slot;
    logic                            sample;
    logic                            drive_val;
    logic                            scl_n;
    logic                            sda_n;

    assign slot_end = (cnt == eeprom_pkg::SCL_LAST);
    assign ack_slot = (bit_idx == 4'd8);
    assign sample   = (cnt == eeprom_pkg::SCL_HIGH_MID);
    assign cmd_pop  = (state == ST_IDLE) && !cmd_empty;

    // line levels for the current slot position
    always_comb
    begin
        scl_n     = (cnt >= eeprom_pkg::SCL_RISE);
        drive_val = 1'b0;
        case (state)
            ST_IDLE:
                scl_n = 1'b1;
            ST_START, ST_RSTART:
                drive_val = (cnt >= eeprom_pkg::SCL_HIGH_MID);    // sda falls, scl high
            ST_STOP:
                drive_val = (cnt < eeprom_pkg::SCL_HIGH_MID);     // sda rises, scl high
            ST_CTRL_W, ST_ADDR, ST_DATA, ST_CTRL_R:
                drive_val = !ack_slot && !shreg[eeprom_pkg::DATA_W-1];
            default:
                drive_val = 1'b0;    // data in and master nack leave sda released
        endcase
        if (state == ST_IDLE)
            sda_n = 1'b0;
        else if (cnt < eeprom_pkg::SCL_LOW_MID)
            sda_n = sda_drive_low;    // sda only moves mid low phase
        else
            sda_n = drive_val;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= ST_IDLE;
            cnt           <= '0;
            bit_idx       <= '0;
            busy          <= 1'b0;
            rsp_push      <= 1'b0;
            nack          <= 1'b0;
            ack_q         <= 1'b0;
            rd_ok         <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            rsp_push      <= 1'b0;
            nack          <= 1'b0;
            scl           <= scl_n;
            sda_drive_low <= sda_n;

            if (state == ST_IDLE || slot_end)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            if (sample && ack_slot)
                ack_q <= !sda_in;

            case (state)
                ST_IDLE:
                    if (cmd_pop)
                    begin
                        busy  <= 1'b1;
                        state <= ST_START;
                    end
                ST_START, ST_RSTART:
                    if (slot_end)
                    begin
                        bit_idx <= '0;
                        state   <= (state == ST_START) ? ST_CTRL_W : ST_CTRL_R;
                    end
                ST_CTRL_W, ST_ADDR, ST_DATA, ST_CTRL_R:
                    if (slot_end)
                    begin
                        bit_idx <= ack_slot ? 4'd0 : bit_idx + 4'd1;
                        if (ack_slot && !ack_q)
                        begin
                            nack  <= 1'b1;    // no ack, give up with a stop
                            state <= ST_STOP;
                        end
                        else if (ack_slot)
                        begin
                            case (state)
                                ST_CTRL_W: state <= ST_ADDR;
                                ST_ADDR:   state <= cmd_q.rd ? ST_RSTART : ST_DATA;
                                ST_CTRL_R: state <= ST_DATA_IN;
                                default:   state <= ST_STOP;
                            endcase
                        end
                    end
                ST_DATA_IN:
                    if (slot_end)
                    begin
                        bit_idx <= ack_slot ? 4'd0 : bit_idx + 4'd1;
                        if (ack_slot)
                        begin
                            rd_ok <= 1'b1;
                            state <= ST_STOP;
                        end
                    end
                ST_STOP:
                    if (slot_end)
                    begin
                        rsp_push <= rd_ok;
                        rd_ok    <= 1'b0;
                        busy     <= 1'b0;
                        state    <= ST_IDLE;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // shift registers and the latched command
    always_ff @(posedge CLK)
    begin
        if (cmd_pop)
            cmd_q <= cmd_data;
        if (slot_end)
        begin
            case (state)
                ST_START:
                    shreg <= {eeprom_pkg::DEV_CODE, cmd_q.addr[eeprom_pkg::ADDR_W-1:8], 1'b0};
                ST_RSTART:
                    shreg <= {eeprom_pkg::DEV_CODE, cmd_q.addr[eeprom_pkg::ADDR_W-1:8], 1'b1};
                ST_CTRL_W:
                    shreg <= ack_slot ? cmd_q.addr[7:0] : shreg << 1;
                ST_ADDR:
                    shreg <= ack_slot ? cmd_q.wdata : shreg << 1;
                ST_DATA, ST_CTRL_R:
                    shreg <= shreg << 1;
                default:
                    shreg <= shreg;
            endcase
        end
        if (sample && state == ST_DATA_IN && !ack_slot)
            rxreg <= {rxreg[eeprom_pkg::DATA_W-2:0], sda_in};    // msb first
        if (state == ST_STOP && slot_end)
            rsp_data <= rxreg;
    end

endmodule

// ==== design/eeprom_subsys.sv ====
`timescale 1ns/100ps

module eeprom_subsys (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_drive_low,
    input  logic        sda_in
);

    eeprom_pkg::eeprom_cmd_t         cmd_in;
    eeprom_pkg::eeprom_cmd_t         cmd_head;
    logic                            cmd_push;
    logic                            cmd_full;
    logic                            cmd_pop;
    logic                            cmd_empty;
    logic [eeprom_pkg::DATA_W-1:0]   rsp_in;
    logic [eeprom_pkg::DATA_W-1:0]   rsp_head;
    logic                            rsp_push;
    logic                            rsp_pop;
    logic                            rsp_empty;
    logic                            busy;
    logic                            nack;

    eeprom_apb_regs u_regs (
        .CLK       (CLK),
        .RESET     (RESET),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_push  (cmd_push),
        .cmd_data  (cmd_in),
        .cmd_full  (cmd_full),
        .rsp_pop   (rsp_pop),
        .rsp_data  (rsp_head),
        .rsp_empty (rsp_empty),
        .busy      (busy),
        .nack      (nack)
    );

    eeprom_fifo #(
        .payload_t (eeprom_pkg::eeprom_cmd_t),
        .DEPTH     (eeprom_pkg::CMD_DEPTH)
    ) u_cmd_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (cmd_push),
        .push_data (cmd_in),
        .full      (cmd_full),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .empty     (cmd_empty)
    );

    // host keeps this one drained, overflow drops the byte
    eeprom_fifo #(
        .payload_t (logic [eeprom_pkg::DATA_W-1:0]),
        .DEPTH     (eeprom_pkg::RSP_DEPTH)
    ) u_rsp_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (rsp_push),
        .push_data (rsp_in),
        .full      (),
        .pop       (rsp_pop),
        .pop_data  (rsp_head),
        .empty     (rsp_empty)
    );

    eeprom_serial_ctrl u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_pop       (cmd_pop),
        .cmd_data      (cmd_head),
        .cmd_empty     (cmd_empty),
        .rsp_push      (rsp_push),
        .rsp_data      (rsp_in),
        .busy          (busy),
        .nack          (nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// ==== sim/eeprom_model.sv ====
`timescale 1ns/100ps

module eeprom_model (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl,
    input  logic       sda,
    input  logic       force_nack,
    input  logic [2:0] exp_block,
    output logic       sda_drive_low,
    output logic       stop_seen,
    output int         errors
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_SEND, M_DONE} mode_t;

    logic [7:0] mem [2048];
    mode_t      mode;
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;    // 8 once the byte is in and 9 in the ack slot
    logic [7:0] rx;
    logic [7:0] tx;
    logic [2:0] blk;
    logic [7:0] addr_lo;
    logic [7:0] wdata;
    logic       wr_pending;
    logic       send_go;

    initial
    begin
        errors = 0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 37) ^ 8'(i >> 3);    // every address bit matters
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            mode          <= M_IDLE;
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
            stop_seen     <= 1'b0;
            wr_pending    <= 1'b0;
            send_go       <= 1'b0;
        end
        else
        begin
            scl_q     <= scl;
            sda_q     <= sda;
            stop_seen <= 1'b0;
            if (scl && scl_q && sda != sda_q)
            begin
                // a repeated start comes one clocked bit into the next byte
                assert (bit_cnt == 0 || (bit_cnt == 1 && !sda)) else
                begin
                    $display("[ERROR] %0t: sda moved while scl high inside a byte", $time);
                    errors++;
                end
                bit_cnt       <= '0;
                sda_drive_low <= 1'b0;
                if (!sda)
                    mode <= M_CTRL;    // start or repeated start
                else
                begin
                    mode       <= M_IDLE;
                    stop_seen  <= 1'b1;
                    wr_pending <= 1'b0;
                    if (wr_pending)
                        mem[{blk, addr_lo}] <= wdata;
                end
            end
            else if (scl && !scl_q && mode != M_IDLE && mode != M_DONE)
            begin
                if (bit_cnt < 8)
                begin
                    rx      <= {rx[6:0], sda};
                    bit_cnt <= bit_cnt + 1'b1;
                end
                else if (mode == M_SEND && !send_go)
                begin
                    assert (sda) else
                    begin
                        $display("[ERROR] %0t: master acked the read byte", $time);
                        errors++;
                    end
                end
            end
            else if (!scl && scl_q)
            begin
                if (mode == M_SEND && bit_cnt >= 1 && bit_cnt <= 7)
                    sda_drive_low <= !tx[7 - bit_cnt];
                else if (bit_cnt == 8)
                begin
                    bit_cnt       <= 4'd9;
                    sda_drive_low <= 1'b0;
                    case (mode)
                        M_CTRL:
                        begin
                            assert (rx[7:4] == eeprom_pkg::DEV_CODE && rx[3:1] == exp_block) else
                            begin
                                $display("[ERROR] %0t: bad control byte %02h, block %0d expected",
                                         $time, rx, exp_block);
                                errors++;
                            end
                            if (force_nack)
                                mode <= M_DONE;
                            else if (rx[0])
                            begin
                                mode          <= M_SEND;
                                send_go       <= 1'b1;
                                tx            <= mem[{rx[3:1], addr_lo}];
                                sda_drive_low <= 1'b1;
                            end
                            else
                            begin
                                blk           <= rx[3:1];
                                mode          <= M_ADDR;
                                sda_drive_low <= 1'b1;
                            end
                        end
                        M_ADDR:
                        begin
                            addr_lo       <= rx;
                            mode          <= M_WDATA;
                            sda_drive_low <= 1'b1;
                        end
                        M_WDATA:
                        begin
                            wdata         <= rx;
                            wr_pending    <= 1'b1;
                            mode          <= M_DONE;
                            sda_drive_low <= 1'b1;
                        end
                        M_SEND:
                            mode <= M_SEND;    // master nack slot still to come
                        default:
                            mode <= M_DONE;
                    endcase
                end
                else if (bit_cnt == 9)
                begin
                    bit_cnt       <= '0;
                    sda_drive_low <= 1'b0;
                    if (send_go)
                    begin
                        send_go       <= 1'b0;
                        sda_drive_low <= !tx[7];    // first read bit
                    end
                    else if (mode == M_SEND)
                        mode <= M_DONE;
                end
            end
        end
    end

endmodule

// ==== sim/tb_eeprom_subsys.sv ====
`timescale 1ns/100ps

module tb_eeprom_subsys;

    localparam int TIMEOUT = 25 * 40 * 2 * eeprom_pkg::SCL_HALF * 3 + 6000;    // 30000

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_drive_low;
    logic        model_low;
    logic        sda_bus;
    logic        force_nack;
    logic [2:0]  exp_block;
    logic        stop_seen;
    int          model_errors;

    logic [7:0]  sb_mem [2048];
    logic [2:0]  blk_q [$];
    integer      seed;
    int          cycles;
    int          errors;
    int          checks;
    int          stalls;
    int          tests_run;
    int          tests_failed;
    int          err_mark;

    assign sda_bus = !(sda_drive_low || model_low);    // wired-and

    eeprom_subsys UUT (
        .CLK           (CLK),
        .RESET         (RESET),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_bus)
    );

    eeprom_model u_model (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_bus),
        .force_nack    (force_nack),
        .exp_block     (exp_block),
        .sda_drive_low (model_low),
        .stop_seen     (stop_seen),
        .errors        (model_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = !CLK;
    end

    always @(posedge CLK)
    begin
        if (stop_seen && blk_q.size() > 0)
            void'(blk_q.pop_front());
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    // block bits the model should see on the bus next
    always @(negedge CLK)
        exp_block = (blk_q.size() > 0) ? blk_q[0] : 3'd0;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else
        begin
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        while (!pready)
        begin
            stalls++;
            @(negedge CLK);
            #1;
        end
        rd  = prdata;
        err = pslverr;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] a, input logic [31:0] d);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, a, d, rd, err);
    endtask

    task automatic apb_read(input logic [3:0] a, output logic [31:0] rd, output logic err);
        apb_access(1'b0, a, 32'd0, rd, err);
    endtask

    task automatic issue_write(input logic [10:0] addr, input logic [7:0] data);
        apb_write(eeprom_pkg::REG_WDATA, 32'(data));
        blk_q.push_back(addr[10:8]);
        apb_write(eeprom_pkg::REG_CMD, 32'(addr));
        sb_mem[addr] = data;
    endtask

    task automatic issue_read(input logic [10:0] addr);
        blk_q.push_back(addr[10:8]);
        apb_write(eeprom_pkg::REG_CMD, (32'd1 << eeprom_pkg::CMD_RD_BIT) | 32'(addr));
    endtask

    // needs two idle status reads in a row so a queued command cannot slip between
    task automatic wait_idle(output logic nack_seen);
        logic [31:0] st;
        logic        err;
        int          quiet;
        nack_seen = 1'b0;
        quiet     = 0;
        while (quiet < 2)
        begin
            apb_read(eeprom_pkg::REG_STATUS, st, err);
            nack_seen = nack_seen | st[3];
            quiet = st[0] ? 0 : quiet + 1;
        end
    endtask

    task automatic read_back(input logic [10:0] addr, input string what);
        logic [31:0] rd;
        logic        err;
        apb_read(eeprom_pkg::REG_RDATA, rd, err);
        check({what, " pslverr"}, 32'(err), 32'd0);
        check({what, " data"}, rd, 32'(sb_mem[addr]));
    endtask

    task automatic write_then_read(input logic [10:0] addr, input logic [7:0] data);
        logic nk_wr;
        logic nk_rd;
        issue_write(addr, data);
        wait_idle(nk_wr);
        issue_read(addr);
        wait_idle(nk_rd);
        check("nack on normal transfer", 32'(nk_wr | nk_rd), 32'd0);
        read_back(addr, $sformatf("read of %03h", addr));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors + model_errors == err_mark)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
        err_mark = errors + model_errors;
    endtask

    initial
    begin
        logic [31:0] rd;
        logic        err;
        logic        nk;
        logic [10:0] addrs [3];
        logic [10:0] a;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 4'h0;
        pwdata     = 32'd0;
        force_nack = 1'b0;
        exp_block  = 3'd0;
        seed       = 32'hd8d0_c7d9;
        RESET      = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        check("scl after reset", 32'(scl), 32'd1);
        check("sda_drive_low after reset", 32'(sda_drive_low), 32'd0);
        apb_read(eeprom_pkg::REG_STATUS, rd, err);
        check("status after reset", rd, 32'd0);
        apb_read(eeprom_pkg::REG_RDATA, rd, err);
        check("empty rdata pslverr", 32'(err), 32'd1);
        check("empty rdata value", rd, 32'd0);
        end_test("reset state");

        write_then_read(11'h0A5, 8'h3C);
        write_then_read(11'h5C3, 8'hE1);
        end_test("write and read in two blocks");

        // the engine holds one command and the fifo four so six must stall
        addrs[0] = 11'h210;
        addrs[1] = 11'h7FE;
        addrs[2] = 11'h311;
        stalls   = 0;
        for (int i = 0; i < 3; i++)
            issue_write(addrs[i], 8'h90 + 8'(i * 5));
        for (int i = 0; i < 3; i++)
            issue_read(addrs[i]);
        check("pready stalled", 32'(stalls > 0), 32'd1);
        wait_idle(nk);
        check("nack on queued transfers", 32'(nk), 32'd0);
        for (int i = 0; i < 3; i++)
            read_back(addrs[i], $sformatf("queued read %0d", i));
        end_test("queued commands");

        for (int i = 0; i < 12; i++)
        begin
            a = 11'($random(seed));
            write_then_read(a, 8'($random(seed)));
        end
        end_test("random writes and reads");

        force_nack = 1'b1;
        issue_read(11'h4A7);
        wait_idle(nk);
        force_nack = 1'b0;
        check("sticky nack set", 32'(nk), 32'd1);
        apb_read(eeprom_pkg::REG_STATUS, rd, err);
        check("status after nack cleared", rd, 32'd0);
        apb_read(eeprom_pkg::REG_RDATA, rd, err);
        check("no read data after nack", 32'(err), 32'd1);
        end_test("forced nack");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d, bus errors %0d",
                 tests_run, tests_failed, checks, errors, model_errors);
        if (errors == 0 && model_errors == 0 && tests_failed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/eeprom_pkg.sv
design/eeprom_fifo.sv
design/eeprom_apb_regs.sv
design/eeprom_serial_ctrl.sv
design/eeprom_subsys.sv
sim/eeprom_model.sv
sim/tb_eeprom_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the EEPROM subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_eeprom_subsys \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
